// ==== project.f ====
+incdir+include
src/ahb_apb_pkg.sv
src/sync_fifo.sv
src/ahb_slave_port.sv
src/apb_master_seq.sv
src/ahb_apb_bridge.sv
test/ahb_apb_checker.sv
test/tb_ahb_apb_bridge.sv

// ==== src/ahb_apb_bridge.sv ====
// AHB-Lite to APB bridge top, single clock HCLK, sync reset rst
// hburst and hmastlock are accepted but bursts go beat by beat
// Request queue holds 4 transfers, response queue 2
`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                            HCLK,
  input  logic                            rst,
  // AHB-Lite slave
  input  logic                            hsel,
  input  logic [ahb_apb_pkg::HADDR_W-1:0]   haddr,
  input  logic                            hwrite,
  input  logic [2:0]                      hsize,
  input  logic [2:0]                      hburst,
  input  logic [3:0]                      hprot,
  input  logic [1:0]                      htrans,
  input  logic                            hmastlock,
  input  logic [ahb_apb_pkg::HDATA_W-1:0]   hwdata,
  input  logic                            hready,
  output logic                            hreadyout,
  output logic                            hresp,
  output logic [ahb_apb_pkg::HDATA_W-1:0]   hrdata,
  // APB master
  output logic                            psel,
  output logic                            penable,
  output logic [ahb_apb_pkg::PADDR_W-1:0]   paddr,
  output logic                            pwrite,
  output logic [ahb_apb_pkg::PDATA_W-1:0]   pwdata,
  output logic [ahb_apb_pkg::PDATA_W/8-1:0] pstrb,
  output logic [2:0]                      pprot,
  input  logic [ahb_apb_pkg::PDATA_W-1:0]   prdata,
  input  logic                            pready,
  input  logic                            pslverr
);

  import ahb_apb_pkg::*;

  // AHB to APB queue
  ahb_req_t req_in, req_out;
  logic     req_push, req_pop, req_full, req_empty;

  // APB to AHB queue
  apb_rsp_t rsp_in, rsp_out;
  logic     rsp_push, rsp_pop, rsp_empty;

  ahb_slave_port u_ahb (
    .HCLK, .rst,
    .hsel, .haddr, .hwrite, .hsize, .hprot, .htrans, .hready, .hwdata,
    .hreadyout, .hresp, .hrdata,
    .req_push (req_push), .req_data (req_in), .req_full (req_full),
    .rsp_pop (rsp_pop), .rsp_data (rsp_out), .rsp_empty (rsp_empty)
  );

  sync_fifo #(.T(ahb_req_t), .DEPTH(FIFO_DEPTH)) u_req_fifo (
    .HCLK, .rst,
    .push (req_push), .push_data (req_in),
    .pop (req_pop), .pop_data (req_out),
    .full (req_full), .empty (req_empty)
  );

  // At most one read outstanding, so full never rises
  sync_fifo #(.T(apb_rsp_t), .DEPTH(2)) u_rsp_fifo (
    .HCLK, .rst,
    .push (rsp_push), .push_data (rsp_in),
    .pop (rsp_pop), .pop_data (rsp_out),
    .full (), .empty (rsp_empty)
  );

  apb_master_seq u_apb (
    .HCLK, .rst,
    .req_pop (req_pop), .req_data (req_out), .req_empty (req_empty),
    .rsp_push (rsp_push), .rsp_data (rsp_in),
    .psel, .penable, .paddr, .pwrite, .pwdata, .pstrb, .pprot,
    .prdata, .pready, .pslverr
  );

endmodule

// ==== src/ahb_apb_pkg.sv ====
// Widths, AHB codes and payload types for the AHB-Lite to APB bridge
// APB shares HCLK and rst with AHB, single APB slave only
// Byte transfers only, one AHB beat maps to one APB transfer
package ahb_apb_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // AHB side
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;

  // APB side, 1 KiB byte space
  localparam int PADDR_W = 10;
  localparam int PDATA_W = 8;

  // Byte lane select within HWDATA/HRDATA
  localparam int LANE_W = 2;

  // Request queue depth, response queue uses 2
  localparam int FIFO_DEPTH = 4;

  ////////////////////////////////////////
  // AHB encodings
  ////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Only legal transfer size
  localparam logic [2:0] HSIZE_BYTE = 3'b000;

  ////////////////////////////////////////
  // Queue payloads
  ////////////////////////////////////////

  // One bridged transfer, AHB to APB
  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    logic               write;
    logic [PDATA_W-1:0] wdata;
    logic [LANE_W-1:0]  lane;
    logic [2:0]         pprot;
  } ahb_req_t;

  // Read completion, APB back to AHB
  typedef struct packed {
    logic [PDATA_W-1:0] rdata;
    logic               slverr;
  } apb_rsp_t;

endpackage

// ==== src/ahb_slave_port.sv ====
// AHB-Lite slave side of the bridge, byte transfers only
// Writes are posted, reads stall until the APB response returns
// Read PSLVERR becomes a two-cycle ERROR, write errors are lost
// Assumes hready equals hreadyout during this slave's data phase
`timescale 1ns/1ps

module ahb_slave_port (
  input  logic                          HCLK,
  input  logic                          rst,
  // AHB-Lite slave
  input  logic                          hsel,
  input  logic [ahb_apb_pkg::HADDR_W-1:0] haddr,
  input  logic                          hwrite,
  input  logic [2:0]                    hsize,
  input  logic [3:0]                    hprot,
  input  logic [1:0]                    htrans,
  input  logic                          hready,
  input  logic [ahb_apb_pkg::HDATA_W-1:0] hwdata,
  output logic                          hreadyout,
  output logic                          hresp,
  output logic [ahb_apb_pkg::HDATA_W-1:0] hrdata,
  // Request queue
  output logic                          req_push,
  output ahb_apb_pkg::ahb_req_t         req_data,
  input  logic                          req_full,
  // Response queue
  output logic                          rsp_pop,
  input  ahb_apb_pkg::apb_rsp_t         rsp_data,
  input  logic                          rsp_empty
);

  import ahb_apb_pkg::*;

  // Data phase states, direction is part of the state
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_RWAIT,
    ST_ERR
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic               accept;
  logic [PADDR_W-1:0] addr_q;
  logic [LANE_W-1:0]  lane_q;
  logic [2:0]         pprot_q;
  logic [PDATA_W-1:0] wbyte;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // NONSEQ or SEQ with hsel and hready
  assign accept = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

  // Captured address phase, payload only
  always_ff @(posedge HCLK) begin
    if (accept) begin
      addr_q  <= haddr[PADDR_W-1:0];
      lane_q  <= haddr[LANE_W-1:0];
      // Instruction, secure, privileged from HPROT
      pprot_q <= {~hprot[0], 1'b0, hprot[1]};
    end
  end

  ////////////////////////////////////////
  // Data phase FSM
  ////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    if (hready) begin
      // Data phase done, next address phase decides
      if (accept) begin
        state_nxt = hwrite ? ST_WRITE : ST_READ;
      end else begin
        state_nxt = ST_IDLE;
      end
    end else begin
      case (state)
        // Read request queued
        ST_READ:  if (!req_full) state_nxt = ST_RWAIT;
        // First ERROR cycle
        ST_RWAIT: if (!rsp_empty && rsp_data.slverr) state_nxt = ST_ERR;
        default:  state_nxt = state;
      endcase
    end
  end

  // Handshake outputs per state
  always_comb begin
    hreadyout = 1'b1;
    hresp     = 1'b0;
    req_push  = 1'b0;
    rsp_pop   = 1'b0;
    case (state)
      ST_WRITE: begin
        // Back-pressure while request queue full
        hreadyout = !req_full;
        req_push  = !req_full;
      end
      ST_READ: begin
        hreadyout = 1'b0;
        req_push  = !req_full;
      end
      ST_RWAIT: begin
        hreadyout = !rsp_empty && !rsp_data.slverr;
        hresp     = !rsp_empty && rsp_data.slverr;
        rsp_pop   = !rsp_empty && !rsp_data.slverr;
      end
      ST_ERR: begin
        // Second ERROR cycle, response retired here
        hresp   = 1'b1;
        rsp_pop = 1'b1;
      end
      default: begin
        hreadyout = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////
  // Lane handling
  ////////////////////////////////////////

  // Addressed byte of the write data
  assign wbyte = hwdata[lane_q * PDATA_W +: PDATA_W];

  always_comb begin
    req_data.addr  = addr_q;
    req_data.write = (state == ST_WRITE);
    req_data.wdata = (state == ST_WRITE) ? wbyte : '0;
    req_data.lane  = lane_q;
    req_data.pprot = pprot_q;
  end

  // Read byte placed in its lane, others zero
  assign hrdata = HDATA_W'(rsp_data.rdata) << (lane_q * PDATA_W);

  // Wider transfers are not split by this bridge
  a_byte_only: assert property (@(posedge HCLK) disable iff (rst)
    accept |-> hsize == HSIZE_BYTE)
    else $error("non-byte AHB transfer accepted");

endmodule

// ==== src/apb_master_seq.sv ====
// APB master sequencer, drains the request queue in order
// One transfer at a time, back-to-back SETUP when more is queued
// Read completions are pushed with PSLVERR, write errors dropped
`timescale 1ns/1ps

module apb_master_seq (
  input  logic                            HCLK,
  input  logic                            rst,
  // Request queue
  output logic                            req_pop,
  input  ahb_apb_pkg::ahb_req_t           req_data,
  input  logic                            req_empty,
  // Response queue
  output logic                            rsp_push,
  output ahb_apb_pkg::apb_rsp_t           rsp_data,
  // APB master
  output logic                            psel,
  output logic                            penable,
  output logic [ahb_apb_pkg::PADDR_W-1:0]   paddr,
  output logic                            pwrite,
  output logic [ahb_apb_pkg::PDATA_W-1:0]   pwdata,
  output logic [ahb_apb_pkg::PDATA_W/8-1:0] pstrb,
  output logic [2:0]                      pprot,
  input  logic [ahb_apb_pkg::PDATA_W-1:0]   prdata,
  input  logic                            pready,
  input  logic                            pslverr
);

  import ahb_apb_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t   state;
  ahb_req_t req_q;
  logic     load;

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  // Take next request when idle or as current one ends
  assign load    = !req_empty && (state == ST_IDLE || (state == ST_ACCESS && pready));
  assign req_pop = load;

  always_ff @(posedge HCLK) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (load) state <= ST_SETUP;
        end
        ST_SETUP: begin
          state <= ST_ACCESS;
        end
        ST_ACCESS: begin
          // Straight to SETUP if another request waits
          if (pready) state <= load ? ST_SETUP : ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Held for the whole transfer
  always_ff @(posedge HCLK) begin
    if (load) begin
      req_q <= req_data;
    end
  end

  ////////////////////////////////////////
  // APB outputs
  ////////////////////////////////////////

  assign psel    = (state != ST_IDLE);
  assign penable = (state == ST_ACCESS);
  assign paddr   = req_q.addr;
  assign pwrite  = req_q.write;
  assign pwdata  = req_q.wdata;
  assign pprot   = req_q.pprot;
  // Strobes low on reads as APB requires
  assign pstrb   = {(PDATA_W/8){req_q.write}};

  // Read completion
  assign rsp_push        = penable && pready && !req_q.write;
  assign rsp_data.rdata  = prdata;
  assign rsp_data.slverr = pslverr;

  // Address and write data frozen through wait states
  a_stable_access: assert property (@(posedge HCLK) disable iff (rst)
    penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else $error("APB request changed during wait state");

endmodule

// ==== src/sync_fifo.sv ====
// Single-clock FIFO, payload type set by parameter T
// Push while full and pop while empty are dropped and flagged
// Head is valid whenever empty is low
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic HCLK,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic full,
  output logic empty
);

  // Storage, no reset on payload
  T mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  // Qualified moves
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == DEPTH);
  assign empty    = (count == 0);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge HCLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, any depth allowed
  always_ff @(posedge HCLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer side must watch full
  a_no_overflow: assert property (@(posedge HCLK) disable iff (rst) push |-> !full)
    else $error("push while full");

  // Consumer side must watch empty
  a_no_underflow: assert property (@(posedge HCLK) disable iff (rst) pop |-> !empty)
    else $error("pop while empty");

endmodule

// ==== test/ahb_apb_checker.sv ====
// Scoreboard between the AHB and APB sides, samples on the falling edge
// Assumes one AHB master and at most one transfer in its data phase
// Mismatches go through the check task of the testbench top
`timescale 1ns/1ps

module ahb_apb_checker (
  input  logic                            HCLK,
  input  logic                            rst,
  // AHB side, observed only
  input  logic                            hsel,
  input  logic [ahb_apb_pkg::HADDR_W-1:0]   haddr,
  input  logic                            hwrite,
  input  logic [1:0]                      htrans,
  input  logic [3:0]                      hprot,
  input  logic                            hready,
  input  logic [ahb_apb_pkg::HDATA_W-1:0]   hwdata,
  input  logic                            hresp,
  input  logic [ahb_apb_pkg::HDATA_W-1:0]   hrdata,
  // APB side, observed only
  input  logic                            psel,
  input  logic                            penable,
  input  logic [ahb_apb_pkg::PADDR_W-1:0]   paddr,
  input  logic                            pwrite,
  input  logic [ahb_apb_pkg::PDATA_W-1:0]   pwdata,
  input  logic [ahb_apb_pkg::PDATA_W/8-1:0] pstrb,
  input  logic [2:0]                      pprot,
  input  logic [ahb_apb_pkg::PDATA_W-1:0]   prdata,
  input  logic                            pready,
  input  logic                            pslverr,
  // Entries still waiting in either queue
  output int                              pending
);

  import ahb_apb_pkg::*;

  ahb_req_t           exp_req_q [$];
  apb_rsp_t           rsp_q [$];
  ahb_req_t           cur;
  apb_rsp_t           rsp;
  logic               dp_valid;
  logic               dp_write;
  logic [HADDR_W-1:0] dp_addr;
  logic [3:0]         dp_prot;

  // APB protection from AHB HPROT
  // Bit 0 privileged, bit 1 non-secure, bit 2 instruction
  function automatic logic [2:0] apb_prot(input logic [3:0] prot);
    logic [2:0] p;
    p[0] = prot[1];
    p[1] = 1'b0;
    p[2] = !prot[0];
    return p;
  endfunction

  always @(negedge HCLK) begin
    if (rst) begin
      exp_req_q.delete();
      rsp_q.delete();
      dp_valid = 1'b0;
    end else begin
      ////////////////////////////////////////
      // APB transfer end, oldest request first
      ////////////////////////////////////////
      if (psel && penable && pready) begin
        if (exp_req_q.size() == 0) begin
          tb_ahb_apb_bridge.stop_with_failure("APB transfer seen with no AHB request queued");
        end else begin
          cur = exp_req_q.pop_front();
          tb_ahb_apb_bridge.check("paddr", paddr, cur.addr);
          tb_ahb_apb_bridge.check("pwrite", pwrite, cur.write);
          tb_ahb_apb_bridge.check("pstrb", pstrb, cur.write);
          tb_ahb_apb_bridge.check("pprot", pprot, cur.pprot);
          if (cur.write) begin
            tb_ahb_apb_bridge.check("pwdata", pwdata, cur.wdata);
          end else begin
            rsp.rdata  = prdata;
            rsp.slverr = pslverr;
            rsp_q.push_back(rsp);
          end
        end
      end

      ////////////////////////////////////////
      // AHB data phase end
      ////////////////////////////////////////
      if (dp_valid && hready) begin
        if (dp_write) begin
          // Write enters the queue once its data is on the bus
          cur.addr  = dp_addr[PADDR_W-1:0];
          cur.write = 1'b1;
          cur.wdata = hwdata[dp_addr[LANE_W-1:0] * PDATA_W +: PDATA_W];
          cur.lane  = dp_addr[LANE_W-1:0];
          cur.pprot = apb_prot(dp_prot);
          exp_req_q.push_back(cur);
        end else if (rsp_q.size() == 0) begin
          tb_ahb_apb_bridge.stop_with_failure("AHB read ended before any APB read returned");
        end else begin
          rsp = rsp_q.pop_front();
          tb_ahb_apb_bridge.check("hresp", hresp, rsp.slverr);
          if (!rsp.slverr) begin
            tb_ahb_apb_bridge.check("hrdata", hrdata,
              HDATA_W'(rsp.rdata) << (dp_addr[LANE_W-1:0] * PDATA_W));
          end
        end
        dp_valid = 1'b0;
      end

      // Accepted address phase, reads queue at once
      if (hsel && hready && htrans[1]) begin
        dp_valid = 1'b1;
        dp_write = hwrite;
        dp_addr  = haddr;
        dp_prot  = hprot;
        if (!hwrite) begin
          cur.addr  = haddr[PADDR_W-1:0];
          cur.write = 1'b0;
          cur.wdata = '0;
          cur.lane  = haddr[LANE_W-1:0];
          cur.pprot = apb_prot(hprot);
          exp_req_q.push_back(cur);
        end
      end
    end
    pending = exp_req_q.size() + rsp_q.size();
  end

endmodule

// ==== include/tb_check.svh ====
// Compare and result helpers, include inside a module body
// First mismatch ends the run
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_pass();
    $display("Result: PASSED");
  endtask

`endif

// ==== test/tb_ahb_apb_bridge.sv ====
// Testbench for the AHB-Lite to APB bridge
// Single AHB master, one transfer at a time, byte transfers in 1 KiB
// APB slave with 0 to 3 wait states, PSLVERR on reads at low byte 8'hFF
// Inputs change 1 ns after the rising edge, outputs sampled at the falling edge
`timescale 1ns/1ps

module tb_ahb_apb_bridge;

  import ahb_apb_pkg::*;

  `include "tb_check.svh"

  localparam int NUM_XFERS = 400;
  localparam int BP_WRITES = FIFO_DEPTH + 2;
  localparam int BP_HOLD   = 24;
  // Idle, AHB phases, APB with waits and queue depth per transfer
  localparam int TIMEOUT_CYCLES = (NUM_XFERS + 2 * BP_WRITES) * (4 + 2 + 5 + FIFO_DEPTH) + BP_HOLD;

  logic                   HCLK;
  logic                   rst;
  logic                   hsel;
  logic [HADDR_W-1:0]     haddr;
  logic                   hwrite;
  logic [2:0]             hsize;
  logic [2:0]             hburst;
  logic [3:0]             hprot;
  logic [1:0]             htrans;
  logic                   hmastlock;
  logic [HDATA_W-1:0]     hwdata;
  logic                   hready;
  logic                   hreadyout;
  logic                   hresp;
  logic [HDATA_W-1:0]     hrdata;
  logic                   psel;
  logic                   penable;
  logic [PADDR_W-1:0]     paddr;
  logic                   pwrite;
  logic [PDATA_W-1:0]     pwdata;
  logic [PDATA_W/8-1:0]   pstrb;
  logic [2:0]             pprot;
  logic [PDATA_W-1:0]     prdata;
  logic                   pready;
  logic                   pslverr;

  logic [PDATA_W-1:0]     dev_mem [1024];
  logic [PDATA_W-1:0]     shadow [1024];
  logic                   hold_pready;
  int                     wait_left;
  int                     cycle_count;
  int                     pending;
  int                     k;

  // Only slave on the bus
  assign hready = hreadyout;

  ahb_apb_bridge dut (.*);

  ahb_apb_checker chk (.*);

  initial HCLK = 1'b0;
  always #4 HCLK = ~HCLK;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge HCLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_with_failure("Timeout, transfers did not finish within the cycle limit");
    end
  end

  // Memory fill, every address bit matters
  function automatic logic [PDATA_W-1:0] fill_byte(input logic [PADDR_W-1:0] a);
    return a[7:0] ^ {4{a[9:8]}};
  endfunction

  ////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////

  always @(posedge HCLK) begin
    #1;
    pready  = 1'b0;
    pslverr = 1'b0;
    if (psel && !penable) begin
      wait_left = $urandom_range(3);
    end else if (psel && penable) begin
      if (wait_left > 0) begin
        wait_left--;
      end else if (!hold_pready) begin
        // Transfer ends at the next edge
        pready = 1'b1;
        if (pwrite) begin
          dev_mem[paddr] = pwdata;
        end else begin
          prdata  = dev_mem[paddr];
          pslverr = (paddr[7:0] == 8'hFF);
        end
      end
    end
  end

  ////////////////////////////////////////
  // AHB master
  ////////////////////////////////////////

  task automatic sample_and_step(output logic rdy, output logic err,
                                 output logic [HDATA_W-1:0] data);
    @(negedge HCLK);
    rdy  = hready;
    err  = hresp;
    data = hrdata;
    @(posedge HCLK);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    repeat (n) begin
      @(posedge HCLK);
      #1;
    end
  endtask

  // One complete transfer, checked against the shadow memory
  task automatic ahb_transfer(input logic write, input logic [PADDR_W-1:0] addr,
                              input logic [PDATA_W-1:0] wbyte);
    logic [HDATA_W-1:0] exp_rdata;
    logic               exp_err;
    logic               err_first;
    logic               rdy;
    logic               err;
    logic [HDATA_W-1:0] rdata;
    exp_err   = !write && (addr[7:0] == 8'hFF);
    exp_rdata = HDATA_W'(shadow[addr]) << (addr[1:0] * PDATA_W);
    if (write) begin
      shadow[addr] = wbyte;
    end
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = HADDR_W'(addr);
    hwrite = write;
    // Data or opcode, user or privileged
    hprot  = {2'b00, 2'($urandom_range(3))};
    rdy    = 1'b0;
    while (!rdy) begin
      sample_and_step(rdy, err, rdata);
    end
    // Data phase, other lanes carry noise
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = $urandom();
    hwdata[addr[1:0] * PDATA_W +: PDATA_W] = wbyte;
    err_first = 1'b0;
    rdy       = 1'b0;
    while (!rdy) begin
      sample_and_step(rdy, err, rdata);
      if (err_first) begin
        check("hreadyout", rdy, 1'b1);
      end
      if (!rdy) begin
        if (!exp_err) begin
          check("hresp", err, 1'b0);
        end
        err_first = err;
      end
    end
    check("hresp", err, exp_err);
    if (exp_err) begin
      check("hresp", err_first, 1'b1);
    end else if (!write) begin
      check("hrdata", rdata, exp_rdata);
    end
  endtask

  initial begin
    logic [PADDR_W-1:0] addr;
    void'($urandom(32'h6680_7ea6));
    rst         = 1'b1;
    hsel        = 1'b0;
    haddr       = '0;
    hwrite      = 1'b0;
    hsize       = HSIZE_BYTE;
    hburst      = 3'b000;
    hprot       = 4'b0011;
    htrans      = HTRANS_IDLE;
    hmastlock   = 1'b0;
    hwdata      = '0;
    prdata      = '0;
    pready      = 1'b0;
    pslverr     = 1'b0;
    hold_pready = 1'b0;
    wait_left   = 0;
    cycle_count = 0;
    for (int a = 0; a < 1024; a++) begin
      dev_mem[a] = fill_byte(PADDR_W'(a));
      shadow[a]  = fill_byte(PADDR_W'(a));
    end
    repeat (4) @(posedge HCLK);
    #1;
    rst = 1'b0;

    // Idle state straight after reset
    @(negedge HCLK);
    check("hreadyout", hreadyout, 1'b1);
    check("hresp", hresp, 1'b0);
    check("psel", psel, 1'b0);
    check("penable", penable, 1'b0);
    @(posedge HCLK);
    #1;

    // Random traffic, some reads aimed at the error bytes
    for (int i = 0; i < NUM_XFERS; i++) begin
      idle_cycles($urandom_range(3));
      addr = $urandom_range(1023);
      if ($urandom_range(15) == 0) begin
        addr[7:0] = 8'hFF;
      end
      ahb_transfer($urandom_range(1), addr, $urandom());
    end

    ////////////////////////////////////////
    // Back-pressure with pready held low
    ////////////////////////////////////////
    hold_pready = 1'b1;
    fork
      begin
        for (k = 0; k < BP_WRITES; k++) begin
          ahb_transfer(1'b1, PADDR_W'(k * 16 + 4), PDATA_W'(8'hA0 + k));
        end
      end
      begin
        repeat (BP_HOLD) @(posedge HCLK);
        @(negedge HCLK);
        // Request queue full, last write stalled
        check("hreadyout", hreadyout, 1'b0);
        hold_pready = 1'b0;
      end
    join
    for (k = 0; k < BP_WRITES; k++) begin
      ahb_transfer(1'b0, PADDR_W'(k * 16 + 4), '0);
    end

    @(negedge HCLK);
    if (pending != 0 || psel) begin
      stop_with_failure("Bridge not idle after the last transfer, requests left over");
    end else begin
      report_pass();
      $finish;
    end
  end

endmodule
